// ==== src/dma_cfg_pkg.sv ====
package dma_cfg_pkg;

    // APB side
    typedef logic [7:0]  apb_addr_t;   // byte address
    typedef logic [31:0] apb_data_t;

    // data path into the membridge write buffer
    typedef logic [63:0] buf_word_t;
    typedef logic [6:0]  page_offset_t; // word index inside one page

    // register map, byte offsets
    localparam apb_addr_t REG_CTRL     = 8'h00; // bit 0 start, self-clearing
    localparam apb_addr_t REG_STATUS   = 8'h04; // bit 0 busy, read-only
    localparam apb_addr_t REG_BUF_ADDR = 8'h08; // low address for membridge
    localparam apb_addr_t REG_PATTERN0 = 8'h0C;
    localparam apb_addr_t REG_PATTERN1 = 8'h10;
    localparam apb_addr_t REG_PATTERN2 = 8'h14;
    localparam apb_addr_t REG_PATTERN3 = 8'h18;

    // control and status bit positions
    localparam int CTRL_START_BIT = 0;
    localparam int STATUS_BUSY_BIT = 0;

endpackage

// ==== src/membr_pkg.sv ====
package membr_pkg;

    // byte-serial command bus
    typedef logic [7:0]  membr_byte_t;

    // one register write on that bus: 16 bit address, 32 bit value
    typedef logic [15:0] membr_reg_addr_t;
    typedef logic [31:0] membr_reg_data_t;

    // membridge register addresses
    localparam membr_reg_addr_t MEMBR_REG_CTRL   = 16'h0200;
    localparam membr_reg_addr_t MEMBR_REG_LOADDR = 16'h0202;
    localparam membr_reg_addr_t MEMBR_REG_SIZE   = 16'h0203;
    localparam membr_reg_addr_t MEMBR_REG_START  = 16'h0204;
    localparam membr_reg_addr_t MEMBR_REG_LEN    = 16'h0205;
    localparam membr_reg_addr_t MEMBR_REG_WIDTH  = 16'h0206;
    localparam membr_reg_addr_t MEMBR_REG_MODE   = 16'h0207;

    // values that do not depend on software or page size
    localparam membr_reg_data_t MEMBR_MODE_VAL  = 32'd3;
    localparam membr_reg_data_t MEMBR_START_VAL = 32'd0;
    localparam membr_reg_data_t MEMBR_CTRL_VAL  = 32'd3; // enable + write direction

endpackage

// ==== src/dma_regs.sv ====
`timescale 1ns/1ps

module dma_regs
    import dma_cfg_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      psel,
    input  logic      penable,
    input  logic      pwrite,
    input  apb_addr_t paddr,
    input  apb_data_t pwdata,
    output apb_data_t prdata,
    output logic      pready,
    output logic      pslverr,
    input  logic      busy,
    output logic      start,
    output apb_data_t buf_addr,
    output apb_data_t pattern0,
    output apb_data_t pattern1,
    output apb_data_t pattern2,
    output apb_data_t pattern3
);

    logic access;   // access phase of a transfer
    logic wr_en;
    logic mapped;

    assign access = psel & penable;
    assign wr_en  = access & pwrite;
    assign pready = 1'b1; // zero wait states

    // read mux and address decode
    always_comb
    begin
        mapped = 1'b1;
        prdata = '0;
        case (paddr)
            REG_CTRL:     prdata = '0; // start reads as zero
            REG_STATUS:   prdata[STATUS_BUSY_BIT] = busy;
            REG_BUF_ADDR: prdata = buf_addr;
            REG_PATTERN0: prdata = pattern0;
            REG_PATTERN1: prdata = pattern1;
            REG_PATTERN2: prdata = pattern2;
            REG_PATTERN3: prdata = pattern3;
            default:      mapped = 1'b0;
        endcase
    end

    // unmapped offset, or a write to the read-only status
    assign pslverr = access & (~mapped | (pwrite & (paddr == REG_STATUS)));

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            start    <= 1'b0;
            buf_addr <= '0;
            pattern0 <= '0;
            pattern1 <= '0;
            pattern2 <= '0;
            pattern3 <= '0;
        end
        else
        begin
            // one-cycle pulse, bit never stored
            start <= wr_en & (paddr == REG_CTRL) & pwdata[CTRL_START_BIT];
            if (wr_en)
            begin
                case (paddr)
                    REG_BUF_ADDR: buf_addr <= pwdata;
                    REG_PATTERN0: pattern0 <= pwdata;
                    REG_PATTERN1: pattern1 <= pwdata;
                    REG_PATTERN2: pattern2 <= pwdata;
                    REG_PATTERN3: pattern3 <= pwdata;
                    default:      ;
                endcase
            end
        end
    end

endmodule

// ==== src/membr_setup_seq.sv ====
`timescale 1ns/1ps

module membr_setup_seq
    import dma_cfg_pkg::*;
    import membr_pkg::*;
#(
    parameter int PAGE_WORDS = 16
)
(
    input  logic            clk,
    input  logic            rst,
    input  logic            start,
    input  apb_data_t       buf_addr,
    input  logic            writer_busy,
    input  logic            page_done,
    output logic            wr_req,
    output membr_reg_addr_t reg_addr,
    output membr_reg_data_t reg_data,
    output logic            page_start,
    output logic            busy
);

    // page size is written to width, length and size alike
    localparam membr_reg_data_t PAGE_LEN = membr_reg_data_t'(PAGE_WORDS);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_MODE,
        ST_WIDTH,
        ST_LEN,
        ST_START,
        ST_SIZE,
        ST_LOADDR,
        ST_CTRL,
        ST_PAGE
    } seq_state_t;

    seq_state_t state;
    seq_state_t state_nxt;
    logic       issued;    // request already sent in this state
    logic       reg_state; // one of the seven register states
    logic       step_done; // writer finished the current frame

    assign reg_state  = (state != ST_IDLE) && (state != ST_PAGE);
    assign wr_req     = reg_state & ~issued & ~writer_busy;
    assign page_start = (state == ST_PAGE) & ~issued;
    assign step_done  = issued & ~writer_busy;
    assign busy       = state != ST_IDLE;

    // address and value held for the whole state
    always_comb
    begin
        reg_addr = '0;
        reg_data = '0;
        case (state)
            ST_MODE:   begin reg_addr = MEMBR_REG_MODE;   reg_data = MEMBR_MODE_VAL;  end
            ST_WIDTH:  begin reg_addr = MEMBR_REG_WIDTH;  reg_data = PAGE_LEN;        end
            ST_LEN:    begin reg_addr = MEMBR_REG_LEN;    reg_data = PAGE_LEN;        end
            ST_START:  begin reg_addr = MEMBR_REG_START;  reg_data = MEMBR_START_VAL; end
            ST_SIZE:   begin reg_addr = MEMBR_REG_SIZE;   reg_data = PAGE_LEN;        end
            ST_LOADDR: begin reg_addr = MEMBR_REG_LOADDR; reg_data = buf_addr;        end
            ST_CTRL:   begin reg_addr = MEMBR_REG_CTRL;   reg_data = MEMBR_CTRL_VAL;  end
            default:   ;
        endcase
    end

    always_comb
    begin
        state_nxt = state;
        case (state)
            ST_IDLE:   if (start)     state_nxt = ST_MODE; // start ignored elsewhere
            ST_MODE:   if (step_done) state_nxt = ST_WIDTH;
            ST_WIDTH:  if (step_done) state_nxt = ST_LEN;
            ST_LEN:    if (step_done) state_nxt = ST_START;
            ST_START:  if (step_done) state_nxt = ST_SIZE;
            ST_SIZE:   if (step_done) state_nxt = ST_LOADDR;
            ST_LOADDR: if (step_done) state_nxt = ST_CTRL;
            ST_CTRL:   if (step_done) state_nxt = ST_PAGE;
            ST_PAGE:   if (page_done) state_nxt = ST_IDLE;
            default:   state_nxt = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= ST_IDLE;
            issued <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // cleared on every state change
            issued <= (state_nxt == state) & (issued | wr_req | page_start);
        end
    end

endmodule

// ==== src/membr_cmd_writer.sv ====
`timescale 1ns/1ps

module membr_cmd_writer
    import membr_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic            wr_req,
    input  membr_reg_addr_t reg_addr,
    input  membr_reg_data_t reg_data,
    output logic            writer_busy,
    output membr_byte_t     cmd_ad,
    output logic            cmd_stb
);

    // byte currently on cmd_ad
    typedef enum logic [2:0] {
        PH_IDLE,
        PH_ADDR_LO,
        PH_ADDR_HI,
        PH_DATA0,
        PH_DATA1,
        PH_DATA2,
        PH_DATA3
    } phase_t;

    phase_t phase;

    assign writer_busy = phase != PH_IDLE;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            phase   <= PH_IDLE;
            cmd_ad  <= '0;
            cmd_stb <= 1'b0;
        end
        else
        begin
            cmd_stb <= 1'b0; // strobe only on the first byte
            case (phase)
                PH_IDLE:
                begin
                    cmd_ad <= '0;
                    if (wr_req)
                    begin
                        phase   <= PH_ADDR_LO;
                        cmd_ad  <= reg_addr[7:0];
                        cmd_stb <= 1'b1;
                    end
                end
                PH_ADDR_LO:
                begin
                    phase  <= PH_ADDR_HI;
                    cmd_ad <= reg_addr[15:8];
                end
                PH_ADDR_HI:
                begin
                    phase  <= PH_DATA0;
                    cmd_ad <= reg_data[7:0]; // data lsb first
                end
                PH_DATA0:
                begin
                    phase  <= PH_DATA1;
                    cmd_ad <= reg_data[15:8];
                end
                PH_DATA1:
                begin
                    phase  <= PH_DATA2;
                    cmd_ad <= reg_data[23:16];
                end
                PH_DATA2:
                begin
                    phase  <= PH_DATA3;
                    cmd_ad <= reg_data[31:24];
                end
                default:
                begin
                    phase  <= PH_IDLE; // end of frame
                    cmd_ad <= '0;
                end
            endcase
        end
    end

endmodule

// ==== src/page_writer.sv ====
`timescale 1ns/1ps

module page_writer
    import dma_cfg_pkg::*;
#(
    parameter int PAGE_WORDS = 16
)
(
    input  logic      clk,
    input  logic      rst,
    input  logic      page_start,
    input  apb_data_t pattern0,
    input  apb_data_t pattern1,
    input  apb_data_t pattern2,
    input  apb_data_t pattern3,
    output logic      xfer_reset_page,
    output logic      buf_wr,
    output buf_word_t buf_wdata,
    output logic      buf_wpage_nxt,
    output logic      page_ready,
    output logic      page_done
);

    localparam page_offset_t LAST_OFFSET = page_offset_t'(PAGE_WORDS - 1);

    typedef enum logic [1:0] {
        PW_IDLE,
        PW_RESET,
        PW_WRITE,
        PW_DONE
    } pw_state_t;

    pw_state_t    state;
    page_offset_t offset;
    logic         last_word;
    apb_data_t    pattern_sel;

    assign last_word = offset == LAST_OFFSET;

    // pattern rotates with the two low offset bits
    always_comb
    begin
        case (offset[1:0])
            2'd0:    pattern_sel = pattern0;
            2'd1:    pattern_sel = pattern1;
            2'd2:    pattern_sel = pattern2;
            default: pattern_sel = pattern3;
        endcase
    end

    assign buf_wdata       = {pattern_sel, 25'd0, offset};
    assign xfer_reset_page = state == PW_RESET;
    assign buf_wr          = state == PW_WRITE;
    assign buf_wpage_nxt   = buf_wr & last_word; // flags ride on the last word
    assign page_ready      = buf_wr & last_word;
    assign page_done       = state == PW_DONE;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state  <= PW_IDLE;
            offset <= '0;
        end
        else
        begin
            case (state)
                PW_IDLE:  if (page_start) state <= PW_RESET;
                PW_RESET:
                begin
                    state  <= PW_WRITE;
                    offset <= '0;
                end
                PW_WRITE:
                begin
                    offset <= offset + 1'b1;
                    if (last_word)
                        state <= PW_DONE;
                end
                default:  state <= PW_IDLE;
            endcase
        end
    end

endmodule

// ==== src/membridge_dma.sv ====
`timescale 1ns/1ps

module membridge_dma
    import dma_cfg_pkg::*;
    import membr_pkg::*;
#(
    parameter int PAGE_WORDS = 16
)
(
    input  logic        clk,
    input  logic        rst,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  apb_addr_t   paddr,
    input  apb_data_t   pwdata,
    output apb_data_t   prdata,
    output logic        pready,
    output logic        pslverr,
    output membr_byte_t cmd_ad,
    output logic        cmd_stb,
    output logic        xfer_reset_page,
    output logic        buf_wr,
    output buf_word_t   buf_wdata,
    output logic        buf_wpage_nxt,
    output logic        page_ready
);

    logic            start;
    logic            busy;
    apb_data_t       buf_addr;
    apb_data_t       pattern0;
    apb_data_t       pattern1;
    apb_data_t       pattern2;
    apb_data_t       pattern3;
    logic            wr_req;
    membr_reg_addr_t reg_addr;
    membr_reg_data_t reg_data;
    logic            writer_busy;
    logic            page_start;
    logic            page_done;

    dma_regs u_dma_regs (
        .clk      (clk),
        .rst      (rst),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .busy     (busy),
        .start    (start),
        .buf_addr (buf_addr),
        .pattern0 (pattern0),
        .pattern1 (pattern1),
        .pattern2 (pattern2),
        .pattern3 (pattern3)
    );

    membr_setup_seq #(
        .PAGE_WORDS (PAGE_WORDS)
    ) u_membr_setup_seq (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .buf_addr    (buf_addr),
        .writer_busy (writer_busy),
        .page_done   (page_done),
        .wr_req      (wr_req),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .page_start  (page_start),
        .busy        (busy)
    );

    membr_cmd_writer u_membr_cmd_writer (
        .clk         (clk),
        .rst         (rst),
        .wr_req      (wr_req),
        .reg_addr    (reg_addr),
        .reg_data    (reg_data),
        .writer_busy (writer_busy),
        .cmd_ad      (cmd_ad),
        .cmd_stb     (cmd_stb)
    );

    page_writer #(
        .PAGE_WORDS (PAGE_WORDS)
    ) u_page_writer (
        .clk             (clk),
        .rst             (rst),
        .page_start      (page_start),
        .pattern0        (pattern0),
        .pattern1        (pattern1),
        .pattern2        (pattern2),
        .pattern3        (pattern3),
        .xfer_reset_page (xfer_reset_page),
        .buf_wr          (buf_wr),
        .buf_wdata       (buf_wdata),
        .buf_wpage_nxt   (buf_wpage_nxt),
        .page_ready      (page_ready),
        .page_done       (page_done)
    );

endmodule

// ==== bench/tb_membridge_dma.sv ====
`timescale 1ns/1ps

module tb_membridge_dma
    import dma_cfg_pkg::*;
    import membr_pkg::*;
();

    localparam int PAGE_WORDS   = 16;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_FRAMES   = 7;
    // about twice six tests of under 150 cycles plus reset
    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    membr_byte_t cmd_ad;
    logic        cmd_stb;
    logic        xfer_reset_page;
    logic        buf_wr;
    buf_word_t   buf_wdata;
    logic        buf_wpage_nxt;
    logic        page_ready;

    // monitor results, only ever appended to
    membr_reg_addr_t frame_addr[$];
    membr_reg_data_t frame_data[$];
    buf_word_t       words[$];
    int              reset_pos[$];  // word count when xfer_reset_page was seen
    int              nxt_pos[$];
    int              ready_pos[$];
    logic [47:0]     frame_shift;
    int              byte_idx = 0;
    int              monitor_errors = 0;

    // where the current transfer starts in the monitor queues
    int frame_base;
    int word_base;
    int reset_base;
    int nxt_base;
    int ready_base;

    int        error_count;
    int        test_errors;
    int        monitor_mark;
    int        checks_done;
    int        test_count;
    int        cycle_count = 0;
    integer    seed;
    apb_data_t pat[4];
    apb_data_t cur_buf_addr;

    membridge_dma #(
        .PAGE_WORDS (PAGE_WORDS)
    ) u_membridge_dma (
        .clk             (clk),
        .rst             (rst),
        .psel            (psel),
        .penable         (penable),
        .pwrite          (pwrite),
        .paddr           (paddr),
        .pwdata          (pwdata),
        .prdata          (prdata),
        .pready          (pready),
        .pslverr         (pslverr),
        .cmd_ad          (cmd_ad),
        .cmd_stb         (cmd_stb),
        .xfer_reset_page (xfer_reset_page),
        .buf_wr          (buf_wr),
        .buf_wdata       (buf_wdata),
        .buf_wpage_nxt   (buf_wpage_nxt),
        .page_ready      (page_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the DUT did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $finish;
        end
    end

    // bus monitors, sampled mid-cycle
    always @(negedge clk)
    begin
        if (byte_idx == 0 && cmd_stb === 1'b1)
        begin
            frame_shift = {cmd_ad, 40'd0};
            byte_idx = 1;
        end
        else if (byte_idx != 0)
        begin
            frame_shift = {cmd_ad, frame_shift[47:8]}; // first byte ends at the bottom
            if (cmd_stb !== 1'b0)
            begin
                $display("ERROR: cmd_stb high inside a command frame");
                monitor_errors++;
            end
            byte_idx++;
            if (byte_idx == 6)
            begin
                frame_addr.push_back(frame_shift[15:0]);
                frame_data.push_back(frame_shift[47:16]);
                byte_idx = 0;
            end
        end
        if (xfer_reset_page === 1'b1)
            reset_pos.push_back(words.size());
        if (buf_wr === 1'b1)
        begin
            if (buf_wpage_nxt === 1'b1)
                nxt_pos.push_back(words.size());
            if (page_ready === 1'b1)
                ready_pos.push_back(words.size());
            words.push_back(buf_wdata);
        end
        else if (buf_wpage_nxt !== 1'b0 || page_ready !== 1'b0)
        begin
            $display("ERROR: page flags high while buf_wr is low");
            monitor_errors++;
        end
    end

    task automatic fail_value(input string name, input string exp, input string act);
        $display("ERROR %s: expected %s, actual %s", name, exp, act);
        error_count++;
        test_errors++;
    endtask

    task automatic check_apb_data(input string name, input apb_data_t exp, input apb_data_t act);
        checks_done++;
        if (act !== exp)
            fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_membr_addr(input string name, input membr_reg_addr_t exp,
                                    input membr_reg_addr_t act);
        checks_done++;
        if (act !== exp)
            fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_membr_data(input string name, input membr_reg_data_t exp,
                                    input membr_reg_data_t act);
        checks_done++;
        if (act !== exp)
            fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_buf_word(input string name, input buf_word_t exp, input buf_word_t act);
        checks_done++;
        if (act !== exp)
            fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks_done++;
        if (act !== exp)
            fail_value(name, $sformatf("%b", exp), $sformatf("%b", act));
    endtask

    task automatic check_number(input string name, input int exp, input int act);
        checks_done++;
        if (act != exp)
            fail_value(name, $sformatf("%0d", exp), $sformatf("%0d", act));
    endtask

    // zero wait states expected in every access phase
    task automatic check_pready();
        checks_done++;
        if (pready !== 1'b1)
        begin
            $display("ERROR: pready low during an APB access phase");
            monitor_errors++;
        end
    endtask

    task automatic end_test(input string name);
        int n;
        n = test_errors + monitor_errors - monitor_mark;
        test_count++;
        if (n == 0)
            $display("test %s: ok", name);
        else
            $display("test %s: %0d errors", name, n);
        test_errors = 0;
        monitor_mark = monitor_errors;
    endtask

    // setup phase, access phase, then idle
    task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        err = pslverr;
        check_pready();
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
        @(posedge clk);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_pready();
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic mark_monitors();
        frame_base = frame_addr.size();
        word_base  = words.size();
        reset_base = reset_pos.size();
        nxt_base   = nxt_pos.size();
        ready_base = ready_pos.size();
    endtask

    task automatic launch_transfer();
        logic err;
        apb_write(REG_CTRL, 32'd1, err);
    endtask

    // poll busy until it drops
    task automatic wait_idle();
        apb_data_t st;
        logic      err;
        st = 32'd1;
        while (st[0] !== 1'b0)
            apb_read(REG_STATUS, st, err);
    endtask

    task automatic check_frames(input string name);
        membr_reg_addr_t exp_addr[7];
        membr_reg_data_t exp_data[7];
        int              n;
        // mode, width, length, start, size, low address, control
        exp_addr = '{16'h0207, 16'h0206, 16'h0205, 16'h0204, 16'h0203, 16'h0202, 16'h0200};
        exp_data = '{32'd3, 32'd16, 32'd16, 32'd0, 32'd16, cur_buf_addr, 32'd3};
        n = frame_addr.size() - frame_base;
        check_number({name, " frame count"}, NUM_FRAMES, n);
        for (int i = 0; i < NUM_FRAMES && i < n; i++)
        begin
            check_membr_addr($sformatf("%s frame %0d address", name, i),
                             exp_addr[i[2:0]], frame_addr[frame_base + i]);
            check_membr_data($sformatf("%s frame %0d data", name, i),
                             exp_data[i[2:0]], frame_data[frame_base + i]);
        end
    endtask

    task automatic check_page(input string name);
        buf_word_t exp;
        int        n;
        check_number({name, " xfer_reset_page count"}, 1, reset_pos.size() - reset_base);
        if (reset_pos.size() > reset_base)
            check_number({name, " words before reset"}, word_base, reset_pos[reset_base]);
        n = words.size() - word_base;
        check_number({name, " word count"}, PAGE_WORDS, n);
        for (int k = 0; k < PAGE_WORDS && k < n; k++)
        begin
            exp = {pat[k[1:0]], 25'd0, k[6:0]}; // pattern in the upper half, offset below
            check_buf_word($sformatf("%s word %0d", name, k), exp, words[word_base + k]);
        end
        check_number({name, " buf_wpage_nxt count"}, 1, nxt_pos.size() - nxt_base);
        if (nxt_pos.size() > nxt_base)
            check_number({name, " buf_wpage_nxt word"}, word_base + PAGE_WORDS - 1,
                         nxt_pos[nxt_base]);
        check_number({name, " page_ready count"}, 1, ready_pos.size() - ready_base);
        if (ready_pos.size() > ready_base)
            check_number({name, " page_ready word"}, word_base + PAGE_WORDS - 1,
                         ready_pos[ready_base]);
    endtask

    task automatic after_reset();
        apb_data_t st;
        logic      err;
        repeat (4)
        begin
            @(negedge clk);
            check_flag("after_reset cmd_stb", 1'b0, cmd_stb);
            check_flag("after_reset buf_wr", 1'b0, buf_wr);
            check_flag("after_reset page_ready", 1'b0, page_ready);
        end
        apb_read(REG_STATUS, st, err);
        check_apb_data("after_reset status", 32'd0, st);
        check_flag("after_reset status pslverr", 1'b0, err);
        end_test("after_reset");
    endtask

    task automatic register_access();
        apb_addr_t regs[5];
        apb_data_t vals[5];
        apb_data_t rd;
        logic      err;
        regs = '{REG_BUF_ADDR, REG_PATTERN0, REG_PATTERN1, REG_PATTERN2, REG_PATTERN3};
        vals = '{32'h0000_1000, 32'ha5a5_0001, 32'h5a5a_0002, 32'hdead_0003, 32'hbeef_0004};
        for (int i = 0; i < 5; i++)
        begin
            apb_write(regs[i[2:0]], vals[i[2:0]], err);
            check_flag($sformatf("register_access write %h pslverr", regs[i[2:0]]), 1'b0, err);
        end
        for (int i = 0; i < 5; i++)
        begin
            apb_read(regs[i[2:0]], rd, err);
            check_apb_data($sformatf("register_access read %h", regs[i[2:0]]), vals[i[2:0]], rd);
        end
        cur_buf_addr = vals[0];
        pat[0] = vals[1];
        pat[1] = vals[2];
        pat[2] = vals[3];
        pat[3] = vals[4];
        apb_read(8'h40, rd, err);
        check_flag("register_access unmapped pslverr", 1'b1, err);
        // every bit but start set, so nothing launches
        apb_write(REG_CTRL, 32'hffff_fffe, err);
        check_flag("register_access ctrl write pslverr", 1'b0, err);
        apb_read(REG_CTRL, rd, err);
        check_apb_data("register_access ctrl read", 32'd0, rd);
        end_test("register_access");
    endtask

    task automatic setup_sequence();
        mark_monitors();
        launch_transfer();
        wait_idle();
        check_frames("setup_sequence");
        end_test("setup_sequence");
    endtask

    // page of the transfer started in setup_sequence
    task automatic page_write();
        check_page("page_write");
        end_test("page_write");
    endtask

    task automatic busy_handling();
        apb_data_t st;
        logic      err;
        mark_monitors();
        launch_transfer();
        apb_read(REG_STATUS, st, err);
        check_apb_data("busy_handling status while busy", 32'd1, st);
        launch_transfer(); // must be ignored
        wait_idle();
        repeat (10) @(negedge clk);
        apb_read(REG_STATUS, st, err);
        check_apb_data("busy_handling status after end", 32'd0, st);
        check_number("busy_handling frame count", NUM_FRAMES, frame_addr.size() - frame_base);
        check_number("busy_handling word count", PAGE_WORDS, words.size() - word_base);
        end_test("busy_handling");
    endtask

    task automatic random_patterns();
        logic err;
        cur_buf_addr = $random(seed);
        for (int i = 0; i < 4; i++)
            pat[i[1:0]] = $random(seed);
        apb_write(REG_BUF_ADDR, cur_buf_addr, err);
        apb_write(REG_PATTERN0, pat[0], err);
        apb_write(REG_PATTERN1, pat[1], err);
        apb_write(REG_PATTERN2, pat[2], err);
        apb_write(REG_PATTERN3, pat[3], err);
        mark_monitors();
        launch_transfer();
        wait_idle();
        check_frames("random_patterns");
        check_page("random_patterns");
        end_test("random_patterns");
    endtask

    initial
    begin
        rst          = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        seed         = 32'h100b_6e67;
        error_count  = 0;
        test_errors  = 0;
        monitor_mark = 0;
        checks_done  = 0;
        test_count   = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;

        after_reset();
        register_access();
        setup_sequence();
        page_write();
        busy_handling();
        random_patterns();

        $display("%0d tests, %0d checks, %0d errors", test_count, checks_done,
                 error_count + monitor_errors);
        if (error_count + monitor_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

// ==== membridge_dma.f ====
src/dma_cfg_pkg.sv
src/membr_pkg.sv
src/dma_regs.sv
src/membr_setup_seq.sv
src/membr_cmd_writer.sv
src/page_writer.sv
src/membridge_dma.sv
bench/tb_membridge_dma.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module tb_membridge_dma -f membridge_dma.f
	./obj_dir/Vtb_membridge_dma | tee /dev/stderr | grep -x "Finished with no errors"

clean:
	rm -rf obj_dir
